//--- verification/IntExecCoreTb.sv
// Testbench for the two-stage integer back end.
// Registers are loaded through the DUT before any random test reads them.
// The reference model keeps its own register image and retires in program order.
// Prediction addresses are random, so JALR mostly mispredicts.
module IntExecCoreTb import IntExecTypes::*; ();

    typedef struct packed {
        IntOpType opType;
        AluCode   aluCode;
        ShiftKind shiftKind;
        logic     useImm;
        DataPath  imm;
        CondCode  cond;
        RegAddr   srcA;
        RegAddr   srcB;
        RegAddr   dst;
        DataPath  pc;
        logic     predTaken;
        DataPath  predAddr;
        int       tag;
    } IssuedOp;

    typedef struct packed {
        DataPath data;
        logic    taken;
        DataPath nextAddr;
        logic    mispred;
    } Outcome;

    typedef logic [REG_COUNT-1:0][DATA_WIDTH-1:0] RegImage;

    logic     clk;
    logic     arstN;
    logic     stall;
    logic     flush;
    logic     issueValid;
    IntOpType opType;
    AluCode   aluCode;
    ShiftKind shiftKind;
    logic     useImm;
    DataPath  imm;
    CondCode  cond;
    RegAddr   srcA;
    RegAddr   srcB;
    RegAddr   dst;
    DataPath  pc;
    logic     predTaken;
    DataPath  predAddr;
    logic     resultValid;
    RegAddr   resultDst;
    DataPath  resultData;
    logic     brValid;
    logic     brTaken;
    DataPath  brNextAddr;
    logic     brMispred;

    IssuedOp pending[$];
    RegImage refRegs;
    IssuedOp headOp;
    Outcome  expOut;
    string   testName;
    int      errorCount;
    int      checkCount;
    int      acceptCount;

    IntExecCore dut_i (
        .clk         (clk),
        .arstN       (arstN),
        .stall       (stall),
        .flush       (flush),
        .issueValid  (issueValid),
        .opType      (opType),
        .aluCode     (aluCode),
        .shiftKind   (shiftKind),
        .useImm      (useImm),
        .imm         (imm),
        .cond        (cond),
        .srcA        (srcA),
        .srcB        (srcB),
        .dst         (dst),
        .pc          (pc),
        .predTaken   (predTaken),
        .predAddr    (predAddr),
        .resultValid (resultValid),
        .resultDst   (resultDst),
        .resultData  (resultData),
        .brValid     (brValid),
        .brTaken     (brTaken),
        .brNextAddr  (brNextAddr),
        .brMispred   (brMispred)
    );

    always #50 clk = ~clk;

    task automatic compareValue(input string name, input DataPath expected,
                                input DataPath actual);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("ERROR %s expected %h actual %h", name, expected, actual);
        end
    endtask

    // Expected outcome of one op, given the architectural state before it
    function automatic Outcome predict(input IssuedOp op, input RegImage regs);
        DataPath    a;
        DataPath    b;
        DataPath    bOrImm;
        logic [4:0] amount;
        logic       condHolds;
        logic       isBr;
        Outcome     res;
        a      = (op.srcA == 0) ? '0 : regs[op.srcA];
        b      = (op.srcB == 0) ? '0 : regs[op.srcB];
        bOrImm = op.useImm ? op.imm : b;
        amount = op.useImm ? op.imm[4:0] : b[4:0];
        res    = '0;
        case (op.cond)
            COND_EQ:  condHolds = (a == b);
            COND_NE:  condHolds = (a != b);
            COND_LT:  condHolds = ($signed(a) < $signed(b));
            COND_LTU: condHolds = (a < b);
            COND_GE:  condHolds = ($signed(a) >= $signed(b));
            COND_GEU: condHolds = (a >= b);
            COND_AL:  condHolds = 1'b1;
            default:  condHolds = 1'b0;
        endcase
        isBr = (op.opType == INT_OP_BR) || (op.opType == INT_OP_JALR);
        if (op.opType == INT_OP_ALU) begin
            case (op.aluCode)
                ALU_ADD:  res.data = a + bOrImm;
                ALU_SUB:  res.data = a - bOrImm;
                ALU_AND:  res.data = a & bOrImm;
                ALU_OR:   res.data = a | bOrImm;
                ALU_XOR:  res.data = a ^ bOrImm;
                ALU_SLT:  res.data = ($signed(a) < $signed(bOrImm)) ? 32'd1 : 32'd0;
                ALU_SLTU: res.data = (a < bOrImm) ? 32'd1 : 32'd0;
                default:  res.data = '0;
            endcase
        end else if (op.opType == INT_OP_SHIFT) begin
            case (op.shiftKind)
                SHIFT_SLL: res.data = a << amount;
                SHIFT_SRL: res.data = a >> amount;
                SHIFT_SRA: res.data = $signed(a) >>> amount;
                default:   res.data = a;
            endcase
        end else begin
            res.data = op.pc + INSN_BYTES;
        end
        res.taken = (op.opType == INT_OP_JALR) || ((op.opType == INT_OP_BR) && condHolds);
        if (!res.taken) begin
            res.nextAddr = op.pc + INSN_BYTES;
        end else if (op.opType == INT_OP_JALR) begin
            res.nextAddr = (a + op.imm) & ~32'd1;
        end else begin
            res.nextAddr = op.pc + op.imm;
        end
        res.mispred = isBr &&
            ((res.taken != op.predTaken) || (res.taken && (res.nextAddr != op.predAddr)));
        return res;
    endfunction

    task automatic checkResult();
        logic isBr;
        if (pending.size() == 0) begin
            errorCount++;
            $display("Result for register %0d appeared with no operation pending", resultDst);
        end else begin
            headOp = pending[0];
            expOut = predict(headOp, refRegs);
            isBr   = (headOp.opType == INT_OP_BR) || (headOp.opType == INT_OP_JALR);
            compareValue({testName, " resultDst"}, headOp.dst, resultDst);
            compareValue({testName, " resultData"}, expOut.data, resultData);
            compareValue({testName, " brValid"}, isBr, brValid);
            compareValue({testName, " brMispred"}, expOut.mispred, brMispred);
            if (isBr) begin
                compareValue({testName, " brTaken"}, expOut.taken, brTaken);
                compareValue({testName, " brNextAddr"}, expOut.nextAddr, brNextAddr);
            end
            // Under stall the same op is checked again at the next edge
            if (!stall) begin
                void'(pending.pop_front());
                if (headOp.dst != 0) begin
                    refRegs[headOp.dst] = expOut.data;
                end
                // The op right behind a mispredict never retires
                if (expOut.mispred && (pending.size() != 0) &&
                    (pending[0].tag == headOp.tag + 1)) begin
                    void'(pending.pop_front());
                end
            end
        end
    endtask

    always @(posedge clk) begin
        if (arstN) begin
            if (resultValid) begin
                checkResult();
            end
            if (flush) begin
                pending.delete();
            end else if (issueValid && !stall) begin
                headOp     = '0;
                headOp.opType    = opType;
                headOp.aluCode   = aluCode;
                headOp.shiftKind = shiftKind;
                headOp.useImm    = useImm;
                headOp.imm       = imm;
                headOp.cond      = cond;
                headOp.srcA      = srcA;
                headOp.srcB      = srcB;
                headOp.dst       = dst;
                headOp.pc        = pc;
                headOp.predTaken = predTaken;
                headOp.predAddr  = predAddr;
                headOp.tag       = acceptCount;
                pending.push_back(headOp);
            end
            if (!stall) begin
                acceptCount++;
            end
        end
    end

    task automatic driveOp(input IssuedOp op, input int stallCycles);
        issueValid = 1'b1;
        opType     = op.opType;
        aluCode    = op.aluCode;
        shiftKind  = op.shiftKind;
        useImm     = op.useImm;
        imm        = op.imm;
        cond       = op.cond;
        srcA       = op.srcA;
        srcB       = op.srcB;
        dst        = op.dst;
        pc         = op.pc;
        predTaken  = op.predTaken;
        predAddr   = op.predAddr;
        if (stallCycles > 0) begin
            stall = 1'b1;
            repeat (stallCycles) @(negedge clk);
            stall = 1'b0;
        end
        @(negedge clk);
    endtask

    task automatic idleCycles(input int n);
        issueValid = 1'b0;
        repeat (n) @(negedge clk);
    endtask

    task automatic waitDrain();
        int cycles;
        cycles = 0;
        while ((pending.size() != 0) && (cycles < 20)) begin
            @(negedge clk);
            cycles++;
        end
        if (pending.size() != 0) begin
            errorCount++;
            $display("Timeout in %s, %0d result(s) never arrived", testName, pending.size());
            pending.delete();
        end
    endtask

    function automatic IssuedOp randomArith();
        IssuedOp op;
        op           = '0;
        op.opType    = ($urandom_range(0, 1) == 0) ? INT_OP_ALU : INT_OP_SHIFT;
        op.aluCode   = AluCode'($urandom_range(0, 6));
        op.shiftKind = ShiftKind'($urandom_range(0, 2));
        op.useImm    = $urandom_range(0, 1);
        op.imm       = $urandom;
        op.srcA      = $urandom_range(0, 15);
        op.srcB      = $urandom_range(0, 15);
        op.dst       = $urandom_range(0, 15);
        return op;
    endfunction

    function automatic IssuedOp randomBranch();
        IssuedOp op;
        op           = randomArith();
        op.opType    = ($urandom_range(0, 3) == 0) ? INT_OP_JALR : INT_OP_BR;
        op.useImm    = 1'b0;
        op.cond      = CondCode'($urandom_range(0, 6));
        op.imm       = DataPath'($signed($urandom_range(0, 511)) - 256) << 2;
        op.pc        = $urandom & ~32'd3;
        op.predTaken = $urandom_range(0, 1);
        case ($urandom_range(0, 2))
            0:       op.predAddr = op.pc + op.imm;
            1:       op.predAddr = op.pc + INSN_BYTES;
            default: op.predAddr = $urandom;
        endcase
        return op;
    endfunction

    // Reads every register back through the ALU into r0
    task automatic readbackRegs();
        IssuedOp op;
        for (int i = 0; i < REG_COUNT; i++) begin
            op         = '0;
            op.opType  = INT_OP_ALU;
            op.aluCode = ALU_OR;
            op.srcA    = i;
            driveOp(op, 0);
        end
        idleCycles(1);
        waitDrain();
    endtask

    initial begin
        IssuedOp op;
        IssuedOp follower;
        RegAddr  prevDst;
        void'($urandom(32'hbce1_47e2));
        clk = 1'b0;
        arstN = 1'b0;
        stall = 1'b0;
        flush = 1'b0;
        issueValid = 1'b0;
        opType = INT_OP_ALU;
        aluCode = ALU_ADD;
        shiftKind = SHIFT_SLL;
        useImm = 1'b0;
        imm = '0;
        cond = COND_EQ;
        srcA = '0;
        srcB = '0;
        dst = '0;
        pc = '0;
        predTaken = 1'b0;
        predAddr = '0;
        refRegs = '0;
        errorCount = 0;
        checkCount = 0;
        acceptCount = 0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        arstN = 1'b1;

        testName = "reset";
        compareValue({testName, " resultValid"}, 0, resultValid);
        compareValue({testName, " brValid"}, 0, brValid);
        compareValue({testName, " brMispred"}, 0, brMispred);

        testName = "init";
        for (int i = 1; i < REG_COUNT; i++) begin
            op        = '0;
            op.useImm = 1'b1;
            op.imm    = $urandom;
            op.dst    = i;
            driveOp(op, 0);
        end
        idleCycles(1);
        waitDrain();

        testName = "random_arith";
        repeat (40) begin
            driveOp(randomArith(), 0);
            idleCycles($urandom_range(0, 2));
        end
        waitDrain();
        readbackRegs();

        testName = "dependent_chain";
        prevDst = $urandom_range(1, 15);
        repeat (30) begin
            op      = randomArith();
            op.srcA = prevDst;
            if ($urandom_range(0, 1) == 1) begin
                op.srcB = prevDst;
            end
            op.dst  = $urandom_range(1, 15);
            prevDst = op.dst;
            driveOp(op, 0);
        end
        idleCycles(1);
        waitDrain();
        readbackRegs();

        testName = "branch";
        repeat (40) begin
            op = ($urandom_range(0, 1) == 0) ? randomBranch() : randomArith();
            driveOp(op, 0);
            idleCycles($urandom_range(0, 1));
        end
        waitDrain();
        readbackRegs();

        testName = "mispredict_kill";
        repeat (8) begin
            op           = randomBranch();
            op.opType    = INT_OP_BR;
            op.cond      = COND_AL;
            op.predTaken = 1'b0;
            driveOp(op, 0);
            follower     = randomArith();
            follower.dst = $urandom_range(1, 15);
            driveOp(follower, 0);
            // Reader sees the register as it was before the killed op
            op         = '0;
            op.aluCode = ALU_OR;
            op.srcA    = follower.dst;
            driveOp(op, 0);
            idleCycles(1);
        end
        waitDrain();

        testName = "stall";
        repeat (30) begin
            op = ($urandom_range(0, 2) == 0) ? randomBranch() : randomArith();
            driveOp(op, $urandom_range(0, 4));
        end
        idleCycles(1);
        waitDrain();
        readbackRegs();

        testName = "flush";
        for (int i = 0; i < 6; i++) begin
            // Odd rounds leave an older op in EX, which retires at the flush edge
            if (i % 2 == 1) begin
                driveOp(randomArith(), 0);
            end
            op     = randomArith();
            op.dst = $urandom_range(1, 15);
            driveOp(op, 0);
            flush = 1'b1;
            driveOp(randomArith(), 0);
            flush = 1'b0;
            idleCycles(2);
            waitDrain();
        end
        readbackRegs();

        $display("Checks run: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

//--- verilog.f
verilog/IntExecTypes.sv
verilog/IntAlu.sv
verilog/Shifter.sv
verilog/BranchResolver.sv
verilog/IntRegisterFile.sv
verilog/IntRegisterReadStage.sv
verilog/IntegerExecutionStage.sv
verilog/IntExecCore.sv
verification/IntExecCoreTb.sv

//--- verilog/BranchResolver.sv
// Resolves direction and target of BR and JALR.
// Outputs for other op types are don't-care apart from isBranch and mispred.
// JALR target has bit 0 cleared.
module BranchResolver import IntExecTypes::*; (
    input  IntOpType opType,
    input  CondCode  cond,
    input  DataPath  opA,
    input  DataPath  opB,
    input  DataPath  imm,
    input  DataPath  pc,
    input  logic     predTaken,
    input  DataPath  predAddr,
    output logic     isBranch,
    output logic     taken,
    output DataPath  nextAddr,
    output logic     mispred
);

    logic condTrue;
    DataPath jumpTarget;

    always_comb begin
        case (cond)
            COND_EQ:  condTrue = (opA == opB);
            COND_NE:  condTrue = (opA != opB);
            COND_LT:  condTrue = ($signed(opA) < $signed(opB));
            COND_LTU: condTrue = (opA < opB);
            COND_GE:  condTrue = ($signed(opA) >= $signed(opB));
            COND_GEU: condTrue = (opA >= opB);
            COND_AL:  condTrue = 1'b1;
            default:  condTrue = 1'b0;
        endcase
    end

    assign jumpTarget = (opA + imm) & ~DataPath'(1);

    always_comb begin
        isBranch = (opType == INT_OP_BR) || (opType == INT_OP_JALR);
        taken    = (opType == INT_OP_JALR) || ((opType == INT_OP_BR) && condTrue);

        if (!taken) begin
            nextAddr = pc + DataPath'(INSN_BYTES);
        end else if (opType == INT_OP_JALR) begin
            nextAddr = jumpTarget;
        end else begin
            nextAddr = pc + imm;
        end

        // Wrong direction, or right direction with the wrong target
        mispred = isBranch &&
            ((taken != predTaken) || (taken && (nextAddr != predAddr)));
    end

endmodule

//--- verilog/IntAlu.sv
// Combinational integer ALU.
// Unused code points return zero.
module IntAlu import IntExecTypes::*; (
    input  AluCode  aluCode,
    input  DataPath opA,
    input  DataPath opB,
    output DataPath aluOut
);

    logic lessSigned;
    logic lessUnsigned;

    assign lessSigned   = $signed(opA) < $signed(opB);
    assign lessUnsigned = opA < opB;

    always_comb begin
        case (aluCode)
            ALU_ADD:  aluOut = opA + opB;
            ALU_SUB:  aluOut = opA - opB;
            ALU_AND:  aluOut = opA & opB;
            ALU_OR:   aluOut = opA | opB;
            ALU_XOR:  aluOut = opA ^ opB;
            // Set-less-than results are zero-extended flags
            ALU_SLT:  aluOut = DataPath'(lessSigned);
            ALU_SLTU: aluOut = DataPath'(lessUnsigned);
            default:  aluOut = '0;
        endcase
    end

endmodule

//--- verilog/IntExecCore.sv
// Two-stage integer back end top level.
// Fixed two-edge latency from issue to result; stall freezes everything.
// The register file is written only when the result is not stalled.
module IntExecCore import IntExecTypes::*; (
    input  logic     clk,
    input  logic     arstN,
    input  logic     stall,
    input  logic     flush,
    input  logic     issueValid,
    input  IntOpType opType,
    input  AluCode   aluCode,
    input  ShiftKind shiftKind,
    input  logic     useImm,
    input  DataPath  imm,
    input  CondCode  cond,
    input  RegAddr   srcA,
    input  RegAddr   srcB,
    input  RegAddr   dst,
    input  DataPath  pc,
    input  logic     predTaken,
    input  DataPath  predAddr,
    output logic     resultValid,
    output RegAddr   resultDst,
    output DataPath  resultData,
    output logic     brValid,
    output logic     brTaken,
    output DataPath  brNextAddr,
    output logic     brMispred
);

    logic     exValid;
    RegAddr   exDst;
    RegAddr   rdAddrA;
    RegAddr   rdAddrB;
    DataPath  rdDataA;
    DataPath  rdDataB;
    logic     rrValid;
    IntOpType rrOpType;
    AluCode   rrAluCode;
    ShiftKind rrShiftKind;
    logic     rrUseImm;
    DataPath  rrImm;
    CondCode  rrCond;
    RegAddr   rrDst;
    DataPath  rrPc;
    logic     rrPredTaken;
    DataPath  rrPredAddr;
    DataPath  rrDataA;
    DataPath  rrDataB;
    logic     fwdA;
    logic     fwdB;

    IntRegisterReadStage rrStageI (
        .clk         (clk),
        .arstN       (arstN),
        .stall       (stall),
        .flush       (flush),
        .exMispred   (brMispred),
        .issueValid  (issueValid),
        .opType      (opType),
        .aluCode     (aluCode),
        .shiftKind   (shiftKind),
        .useImm      (useImm),
        .imm         (imm),
        .cond        (cond),
        .srcA        (srcA),
        .srcB        (srcB),
        .dst         (dst),
        .pc          (pc),
        .predTaken   (predTaken),
        .predAddr    (predAddr),
        .exValid     (exValid),
        .exDst       (exDst),
        .rdAddrA     (rdAddrA),
        .rdAddrB     (rdAddrB),
        .rdDataA     (rdDataA),
        .rdDataB     (rdDataB),
        .rrValid     (rrValid),
        .rrOpType    (rrOpType),
        .rrAluCode   (rrAluCode),
        .rrShiftKind (rrShiftKind),
        .rrUseImm    (rrUseImm),
        .rrImm       (rrImm),
        .rrCond      (rrCond),
        .rrDst       (rrDst),
        .rrPc        (rrPc),
        .rrPredTaken (rrPredTaken),
        .rrPredAddr  (rrPredAddr),
        .rrDataA     (rrDataA),
        .rrDataB     (rrDataB),
        .fwdA        (fwdA),
        .fwdB        (fwdB)
    );

    IntegerExecutionStage exStageI (
        .clk         (clk),
        .arstN       (arstN),
        .stall       (stall),
        .flush       (flush),
        .rrValid     (rrValid),
        .rrOpType    (rrOpType),
        .rrAluCode   (rrAluCode),
        .rrShiftKind (rrShiftKind),
        .rrUseImm    (rrUseImm),
        .rrImm       (rrImm),
        .rrCond      (rrCond),
        .rrDst       (rrDst),
        .rrPc        (rrPc),
        .rrPredTaken (rrPredTaken),
        .rrPredAddr  (rrPredAddr),
        .rrDataA     (rrDataA),
        .rrDataB     (rrDataB),
        .fwdA        (fwdA),
        .fwdB        (fwdB),
        .exValid     (exValid),
        .exDst       (exDst),
        .resultValid (resultValid),
        .resultDst   (resultDst),
        .resultData  (resultData),
        .brValid     (brValid),
        .brTaken     (brTaken),
        .brNextAddr  (brNextAddr),
        .brMispred   (brMispred)
    );

    // Write-back at the edge that retires the result
    IntRegisterFile regFileI (
        .clk     (clk),
        .arstN   (arstN),
        .rdAddrA (rdAddrA),
        .rdAddrB (rdAddrB),
        .rdDataA (rdDataA),
        .rdDataB (rdDataB),
        .wrEn    (resultValid && !stall),
        .wrAddr  (resultDst),
        .wrData  (resultData)
    );

endmodule

//--- verilog/IntExecTypes.sv
// Shared widths and encodings for the integer back end.
// Immediates arrive already sign-extended to DATA_WIDTH.
// Encodings not listed in an enum are treated as illegal by the users.
package IntExecTypes;

    localparam int DATA_WIDTH         = 32;
    localparam int REG_COUNT          = 16;
    localparam int REG_ADDR_WIDTH     = $clog2(REG_COUNT);
    localparam int INSN_BYTES         = 4;
    localparam int SHIFT_AMOUNT_WIDTH = 5;

    typedef logic [DATA_WIDTH-1:0]         DataPath;
    typedef logic [REG_ADDR_WIDTH-1:0]     RegAddr;
    typedef logic [SHIFT_AMOUNT_WIDTH-1:0] ShiftAmount;

    // Operation class, picks the result source
    typedef enum logic [1:0] {
        INT_OP_ALU   = 2'd0,
        INT_OP_SHIFT = 2'd1,
        INT_OP_BR    = 2'd2,
        INT_OP_JALR  = 2'd3
    } IntOpType;

    typedef enum logic [2:0] {
        ALU_ADD  = 3'd0,
        ALU_SUB  = 3'd1,
        ALU_AND  = 3'd2,
        ALU_OR   = 3'd3,
        ALU_XOR  = 3'd4,
        ALU_SLT  = 3'd5,
        ALU_SLTU = 3'd6
    } AluCode;

    typedef enum logic [1:0] {
        SHIFT_SLL = 2'd0,
        SHIFT_SRL = 2'd1,
        SHIFT_SRA = 2'd2
    } ShiftKind;

    // Branch conditions, AL is unconditional
    typedef enum logic [2:0] {
        COND_EQ  = 3'd0,
        COND_NE  = 3'd1,
        COND_LT  = 3'd2,
        COND_LTU = 3'd3,
        COND_GE  = 3'd4,
        COND_GEU = 3'd5,
        COND_AL  = 3'd6
    } CondCode;

endpackage

//--- verilog/IntRegisterFile.sv
// 16 x 32 register file, two async read ports, one write port.
// Register 0 reads zero and ignores writes. Contents are not reset.
module IntRegisterFile import IntExecTypes::*; (
    input  logic    clk,
    input  logic    arstN,
    input  RegAddr  rdAddrA,
    input  RegAddr  rdAddrB,
    output DataPath rdDataA,
    output DataPath rdDataB,
    input  logic    wrEn,
    input  RegAddr  wrAddr,
    input  DataPath wrData
);

    DataPath regs [REG_COUNT];

    always_ff @(posedge clk) begin
        if (wrEn && (wrAddr != '0)) begin
            regs[wrAddr] <= wrData;
        end
    end

    assign rdDataA = (rdAddrA == '0) ? '0 : regs[rdAddrA];
    assign rdDataB = (rdAddrB == '0) ? '0 : regs[rdAddrB];

    // Write address must be known whenever a write is requested
    assert property (@(posedge clk) disable iff (!arstN)
        wrEn |-> !$isunknown(wrAddr));

endmodule

//--- verilog/IntRegisterReadStage.sv
// Issue register and operand read.
// The op here is killed when the execution stage reports a mispredict.
// Forward flags only look one stage ahead; older results come from the file.
module IntRegisterReadStage import IntExecTypes::*; (
    input  logic     clk,
    input  logic     arstN,
    input  logic     stall,
    input  logic     flush,
    input  logic     exMispred,
    input  logic     issueValid,
    input  IntOpType opType,
    input  AluCode   aluCode,
    input  ShiftKind shiftKind,
    input  logic     useImm,
    input  DataPath  imm,
    input  CondCode  cond,
    input  RegAddr   srcA,
    input  RegAddr   srcB,
    input  RegAddr   dst,
    input  DataPath  pc,
    input  logic     predTaken,
    input  DataPath  predAddr,
    input  logic     exValid,
    input  RegAddr   exDst,
    output RegAddr   rdAddrA,
    output RegAddr   rdAddrB,
    input  DataPath  rdDataA,
    input  DataPath  rdDataB,
    output logic     rrValid,
    output IntOpType rrOpType,
    output AluCode   rrAluCode,
    output ShiftKind rrShiftKind,
    output logic     rrUseImm,
    output DataPath  rrImm,
    output CondCode  rrCond,
    output RegAddr   rrDst,
    output DataPath  rrPc,
    output logic     rrPredTaken,
    output DataPath  rrPredAddr,
    output DataPath  rrDataA,
    output DataPath  rrDataB,
    output logic     fwdA,
    output logic     fwdB
);

    logic   validQ;
    RegAddr srcAQ;
    RegAddr srcBQ;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            validQ <= 1'b0;
        end else if (flush) begin
            validQ <= 1'b0;
        end else if (!stall) begin
            validQ <= issueValid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            rrOpType    <= opType;
            rrAluCode   <= aluCode;
            rrShiftKind <= shiftKind;
            rrUseImm    <= useImm;
            rrImm       <= imm;
            rrCond      <= cond;
            srcAQ       <= srcA;
            srcBQ       <= srcB;
            rrDst       <= dst;
            rrPc        <= pc;
            rrPredTaken <= predTaken;
            rrPredAddr  <= predAddr;
        end
    end

    // Younger op never reaches EX behind a mispredict
    assign rrValid = validQ && !exMispred;

    assign rdAddrA = srcAQ;
    assign rdAddrB = srcBQ;
    assign rrDataA = rdDataA;
    assign rrDataB = rdDataB;

    // Producer still in EX and not yet in the file
    assign fwdA = (srcAQ != '0) && exValid && (srcAQ == exDst);
    assign fwdB = (srcBQ != '0) && exValid && (srcBQ == exDst);

endmodule

//--- verilog/IntegerExecutionStage.sv
// Execution register, operand select, ALU/shift/branch and result mux.
// lastResult holds the result of the op that left this stage last.
// Results and branch outcome are combinational from the stage register.
module IntegerExecutionStage import IntExecTypes::*; (
    input  logic     clk,
    input  logic     arstN,
    input  logic     stall,
    input  logic     flush,
    input  logic     rrValid,
    input  IntOpType rrOpType,
    input  AluCode   rrAluCode,
    input  ShiftKind rrShiftKind,
    input  logic     rrUseImm,
    input  DataPath  rrImm,
    input  CondCode  rrCond,
    input  RegAddr   rrDst,
    input  DataPath  rrPc,
    input  logic     rrPredTaken,
    input  DataPath  rrPredAddr,
    input  DataPath  rrDataA,
    input  DataPath  rrDataB,
    input  logic     fwdA,
    input  logic     fwdB,
    output logic     exValid,
    output RegAddr   exDst,
    output logic     resultValid,
    output RegAddr   resultDst,
    output DataPath  resultData,
    output logic     brValid,
    output logic     brTaken,
    output DataPath  brNextAddr,
    output logic     brMispred
);

    logic     validQ;
    IntOpType opTypeQ;
    AluCode   aluCodeQ;
    ShiftKind shiftKindQ;
    logic     useImmQ;
    DataPath  immQ;
    CondCode  condQ;
    RegAddr   dstQ;
    DataPath  pcQ;
    logic     predTakenQ;
    DataPath  predAddrQ;
    DataPath  dataAQ;
    DataPath  dataBQ;
    logic     fwdAQ;
    logic     fwdBQ;
    DataPath  lastResult;

    DataPath opA;
    DataPath opB;
    DataPath aluOpB;
    DataPath aluOut;
    DataPath shiftOut;
    DataPath linkAddr;
    logic    isBranch;
    logic    taken;
    DataPath nextAddr;
    logic    mispred;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            validQ <= 1'b0;
        end else if (flush) begin
            validQ <= 1'b0;
        end else if (!stall) begin
            validQ <= rrValid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            opTypeQ    <= rrOpType;
            aluCodeQ   <= rrAluCode;
            shiftKindQ <= rrShiftKind;
            useImmQ    <= rrUseImm;
            immQ       <= rrImm;
            condQ      <= rrCond;
            dstQ       <= rrDst;
            pcQ        <= rrPc;
            predTakenQ <= rrPredTaken;
            predAddrQ  <= rrPredAddr;
            dataAQ     <= rrDataA;
            dataBQ     <= rrDataB;
            fwdAQ      <= fwdA;
            fwdBQ      <= fwdB;
            // Captured as the current op leaves, used by the next one
            lastResult <= resultData;
        end
    end

    // Operand bypass from the previous op
    assign opA    = fwdAQ ? lastResult : dataAQ;
    assign opB    = fwdBQ ? lastResult : dataBQ;
    assign aluOpB = useImmQ ? immQ : opB;

    IntAlu aluI (
        .aluCode (aluCodeQ),
        .opA     (opA),
        .opB     (aluOpB),
        .aluOut  (aluOut)
    );

    Shifter shifterI (
        .shiftKind (shiftKindQ),
        .useImm    (useImmQ),
        .immAmount (immQ[SHIFT_AMOUNT_WIDTH-1:0]),
        .regAmount (opB[SHIFT_AMOUNT_WIDTH-1:0]),
        .dataIn    (opA),
        .dataOut   (shiftOut)
    );

    BranchResolver branchI (
        .opType    (opTypeQ),
        .cond      (condQ),
        .opA       (opA),
        .opB       (opB),
        .imm       (immQ),
        .pc        (pcQ),
        .predTaken (predTakenQ),
        .predAddr  (predAddrQ),
        .isBranch  (isBranch),
        .taken     (taken),
        .nextAddr  (nextAddr),
        .mispred   (mispred)
    );

    assign linkAddr = pcQ + DataPath'(INSN_BYTES);

    always_comb begin
        case (opTypeQ)
            INT_OP_ALU:   resultData = aluOut;
            INT_OP_SHIFT: resultData = shiftOut;
            default:      resultData = linkAddr;
        endcase
    end

    assign exValid     = validQ;
    assign exDst       = dstQ;
    assign resultValid = validQ;
    assign resultDst   = dstQ;

    assign brValid    = validQ && isBranch;
    assign brTaken    = taken;
    assign brNextAddr = nextAddr;
    assign brMispred  = validQ && mispred;

    // Resolver must only flag mispredicts on branch ops
    assert property (@(posedge clk) disable iff (!arstN) brMispred |-> brValid);

    assert property (@(posedge clk) disable iff (!arstN) !$isunknown(resultValid));

endmodule

//--- verilog/Shifter.sv
// Combinational barrel shifter.
// Only the low SHIFT_AMOUNT_WIDTH bits of either amount are used.
module Shifter import IntExecTypes::*; (
    input  ShiftKind   shiftKind,
    input  logic       useImm,
    input  ShiftAmount immAmount,
    input  ShiftAmount regAmount,
    input  DataPath    dataIn,
    output DataPath    dataOut
);

    ShiftAmount amount;

    assign amount = useImm ? immAmount : regAmount;

    always_comb begin
        case (shiftKind)
            SHIFT_SLL: dataOut = dataIn << amount;
            SHIFT_SRL: dataOut = dataIn >> amount;
            // Arithmetic shift fills with the sign bit
            SHIFT_SRA: dataOut = DataPath'($signed(dataIn) >>> amount);
            default:   dataOut = dataIn;
        endcase
    end

endmodule
